/* hw/spi_flash_apb_top.sv */
`timescale 1ns/1ps
`include "spi_flash_defs.svh"

module spi_flash_apb_top
  import spi_flash_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic [31:0]            paddr_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [31:0]            pwdata_i,
  input  logic [3:0]             pstrb_i,
  output logic                   pready_o,
  output logic [31:0]            prdata_o,
  output logic                   pslverr_o,
  output logic                   spi_sck_o,
  output logic [`SPI_SS_NUM-1:0] spi_ss_o,
  output logic                   spi_mosi_o,
  input  logic                   spi_miso_i,
  output logic                   spi_irq_o
);

  logic        in_flash;
  logic        in_regs;
  logic        access;
  logic        flash_rd;
  logic        bad_access;
  logic        err_q;
  logic        seq_ready;
  logic [31:0] seq_rdata;
  reg_req_t    apb_req;
  reg_req_t    seq_req;
  reg_req_t    reg_req;
  reg_rsp_t    reg_rsp;

  // Window decode
  assign in_flash = (paddr_i >= `SPI_FLASH_START) && (paddr_i <= `SPI_FLASH_END);
  assign in_regs  = (paddr_i >= `SPI_REGS_START) && (paddr_i <= `SPI_REGS_END);

  // APB access phase
  assign access     = psel_i && penable_i;
  assign flash_rd   = access && in_flash && !pwrite_i;
  // Unmapped address or flash write
  assign bad_access = access && ((!in_flash && !in_regs) || (in_flash && pwrite_i));

  // One-cycle error response
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      err_q <= 1'b0;
    end else begin
      err_q <= bad_access && !err_q;
    end
  end

  // Direct register request from APB
  assign apb_req = '{adr:   paddr_i[4:0],
                     wdata: pwdata_i,
                     strb:  pwrite_i ? pstrb_i : 4'h0,
                     we:    pwrite_i,
                     stb:   access && in_regs};

  // Sequencer owns the port inside the flash window
  assign reg_req = in_flash ? seq_req : apb_req;

  xip_read_sequencer u_seq (
    .clock        (clock),
    .reset        (reset),
    .start_i      (flash_rd),
    .flash_addr_i (paddr_i[23:0]),
    .rsp_i        (reg_rsp),
    .req_o        (seq_req),
    .ready_o      (seq_ready),
    .rdata_o      (seq_rdata)
  );

  spi_master_regs u_regs (
    .clock  (clock),
    .reset  (reset),
    .req_i  (reg_req),
    .rsp_o  (reg_rsp),
    .ss_o   (spi_ss_o),
    .sck_o  (spi_sck_o),
    .mosi_o (spi_mosi_o),
    .miso_i (spi_miso_i),
    .irq_o  (spi_irq_o)
  );

  assign pready_o  = err_q || (in_regs && reg_rsp.ack) || seq_ready;
  assign pslverr_o = err_q || (in_regs && reg_rsp.ack && reg_rsp.err);
  assign prdata_o  = in_flash ? seq_rdata : reg_rsp.rdata;

endmodule

/* hw/spi_flash_defs.svh */
`ifndef SPI_FLASH_DEFS_SVH
`define SPI_FLASH_DEFS_SVH

// XIP flash window, read only
`define SPI_FLASH_START 32'h3000_0000
`define SPI_FLASH_END   32'h3FFF_FFFF

// SPI master register window
`define SPI_REGS_START  32'h1000_1000
`define SPI_REGS_END    32'h1000_1FFF

// Number of slave-select lines
`define SPI_SS_NUM 8

// Register offsets on the internal port
`define SPI_REG_RX0_OFS     5'h00
`define SPI_REG_RX1_OFS     5'h04
`define SPI_REG_CTRL_OFS    5'h10
`define SPI_REG_DIVIDER_OFS 5'h14
`define SPI_REG_SS_OFS      5'h18

// Flash read opcode and XIP transfer setup
`define FLASH_READ_CMD 8'h03
// SCK period of 4 clocks
`define XIP_DIVIDER    16'd1
`define XIP_CHAR_LEN   7'd64

// CTRL register fields
`define CTRL_CHAR_LEN_W 7
`define CTRL_GO_BSY_BIT 8
`define CTRL_IE_BIT     12

`endif

/* hw/spi_flash_pkg.sv */
`include "spi_flash_defs.svh"

package spi_flash_pkg;

  // Register offsets, RX and TX share a slot
  typedef enum logic [4:0] {
    REG_RX0     = `SPI_REG_RX0_OFS,
    REG_RX1     = `SPI_REG_RX1_OFS,
    REG_CTRL    = `SPI_REG_CTRL_OFS,
    REG_DIVIDER = `SPI_REG_DIVIDER_OFS,
    REG_SS      = `SPI_REG_SS_OFS
  } spi_reg_addr_e;

  // Write enable selects TX over RX
  localparam spi_reg_addr_e REG_TX0 = REG_RX0;
  localparam spi_reg_addr_e REG_TX1 = REG_RX1;

  // Register-port request
  typedef struct packed {
    logic [4:0]  adr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic        we;
    logic        stb;
  } reg_req_t;

  // Register-port response, err valid with ack
  typedef struct packed {
    logic [31:0] rdata;
    logic        ack;
    logic        err;
  } reg_rsp_t;

  // XIP sequencer steps
  typedef enum logic [3:0] {
    IDLE,
    LOAD_CMD,
    SET_DIVIDER,
    SELECT,
    START,
    POLL,
    DESELECT,
    READ_RX,
    DONE
  } xip_state_e;

endpackage

/* hw/spi_master_regs.sv */
`timescale 1ns/1ps
`include "spi_flash_defs.svh"

module spi_master_regs
  import spi_flash_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  reg_req_t               req_i,
  output reg_rsp_t               rsp_o,
  output logic [`SPI_SS_NUM-1:0] ss_o,
  output logic                   sck_o,
  output logic                   mosi_o,
  input  logic                   miso_i,
  output logic                   irq_o
);

  spi_reg_addr_e                  adr_e;
  logic                           serve;
  logic                           addr_ok;
  logic                           wr_en;
  logic                           wr_ctrl;
  logic [31:0]                    cur_word;
  logic [31:0]                    wr_word;
  logic [31:0]                    ctrl_word;
  logic                           ack_q;
  logic                           gap_q;
  logic                           err_q;
  logic [31:0]                    rdata_q;
  logic [63:0]                    tx_q;
  logic [`CTRL_CHAR_LEN_W-1:0]    ctrl_len_q;
  logic                           ctrl_ie_q;
  logic [15:0]                    divider_q;
  logic [`SPI_SS_NUM-1:0]         ss_q;
  logic                           start_q;
  logic                           irq_q;
  logic                           eng_busy;
  logic                           eng_done;
  logic [63:0]                    rx_word;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    for (int i = 0; i < 4; i++) begin
      res[8*i +: 8] = strb[i] ? new_val[8*i +: 8] : old_val[8*i +: 8];
    end
    return res;
  endfunction

  assign adr_e = spi_reg_addr_e'(req_i.adr);

  // No service on the ack cycle or the cycle after it
  assign serve = req_i.stb && !ack_q && !gap_q;

  // Live CTRL view, GO_BSY covers the pending start too
  always_comb begin
    ctrl_word = 32'd0;
    ctrl_word[`CTRL_CHAR_LEN_W-1:0] = ctrl_len_q;
    ctrl_word[`CTRL_GO_BSY_BIT]     = eng_busy | start_q;
    ctrl_word[`CTRL_IE_BIT]         = ctrl_ie_q;
  end

  // Read data, also the old value for byte merges
  always_comb begin
    cur_word = 32'd0;
    addr_ok  = 1'b1;
    case (adr_e)
      REG_RX0:     cur_word = req_i.we ? tx_q[31:0] : rx_word[31:0];
      REG_RX1:     cur_word = req_i.we ? tx_q[63:32] : rx_word[63:32];
      REG_CTRL:    cur_word = ctrl_word;
      REG_DIVIDER: cur_word = {16'd0, divider_q};
      REG_SS:      cur_word = {{(32-`SPI_SS_NUM){1'b0}}, ss_q};
      default:     addr_ok  = 1'b0;
    endcase
  end

  assign wr_word = merge_bytes(cur_word, req_i.wdata, req_i.strb);
  assign wr_en   = serve && req_i.we && addr_ok;
  assign wr_ctrl = wr_en && (adr_e == REG_CTRL);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ack_q      <= 1'b0;
      gap_q      <= 1'b0;
      err_q      <= 1'b0;
      ctrl_len_q <= '0;
      ctrl_ie_q  <= 1'b0;
      divider_q  <= `XIP_DIVIDER;
      ss_q       <= '0;
      start_q    <= 1'b0;
      irq_q      <= 1'b0;
    end else begin
      ack_q   <= serve;
      gap_q   <= ack_q;
      err_q   <= serve && !addr_ok;
      // Start only from idle
      start_q <= wr_ctrl && wr_word[`CTRL_GO_BSY_BIT] && !(eng_busy || start_q);
      if (wr_ctrl) begin
        ctrl_len_q <= wr_word[`CTRL_CHAR_LEN_W-1:0];
        ctrl_ie_q  <= wr_word[`CTRL_IE_BIT];
      end
      if (wr_en && adr_e == REG_DIVIDER) begin
        divider_q <= wr_word[15:0];
      end
      if (wr_en && adr_e == REG_SS) begin
        ss_q <= wr_word[`SPI_SS_NUM-1:0];
      end
      // Completion sets, CTRL write clears
      if (eng_done && ctrl_ie_q) begin
        irq_q <= 1'b1;
      end else if (wr_ctrl) begin
        irq_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (serve) begin
      rdata_q <= cur_word;
    end
    if (wr_en && adr_e == REG_TX0) begin
      tx_q[31:0] <= wr_word;
    end
    if (wr_en && adr_e == REG_TX1) begin
      tx_q[63:32] <= wr_word;
    end
  end

  spi_shift_engine u_engine (
    .clock      (clock),
    .reset      (reset),
    .start_i    (start_q),
    .char_len_i (ctrl_len_q),
    .divider_i  (divider_q),
    .tx_i       (tx_q),
    .miso_i     (miso_i),
    .busy_o     (eng_busy),
    .done_o     (eng_done),
    .rx_o       (rx_word),
    .sck_o      (sck_o),
    .mosi_o     (mosi_o)
  );

  assign rsp_o = '{rdata: rdata_q, ack: ack_q, err: err_q};
  // Select lines are active low
  assign ss_o  = ~ss_q;
  assign irq_o = irq_q;

endmodule

/* hw/spi_shift_engine.sv */
`timescale 1ns/1ps

module spi_shift_engine (
  input  logic        clock,
  input  logic        reset,
  input  logic        start_i,
  input  logic [6:0]  char_len_i,
  input  logic [15:0] divider_i,
  input  logic [63:0] tx_i,
  input  logic        miso_i,
  output logic        busy_o,
  output logic        done_o,
  output logic [63:0] rx_o,
  output logic        sck_o,
  output logic        mosi_o
);

  localparam int unsigned MAX_LEN = 64;

  logic        busy_q;
  logic        done_q;
  logic        sck_q;
  logic        miso_q;
  logic [15:0] div_cnt_q;
  logic [6:0]  bit_cnt_q;
  logic [63:0] shift_q;
  logic [6:0]  len_eff;
  logic        half_tick;

  // Zero or oversize length means a full 64-bit frame
  assign len_eff = (char_len_i == 7'd0 || char_len_i > 7'(MAX_LEN)) ?
                   7'(MAX_LEN) : char_len_i;

  // End of one SCK half period
  assign half_tick = busy_q && (div_cnt_q == 16'd0);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      sck_q     <= 1'b0;
      div_cnt_q <= 16'd0;
      bit_cnt_q <= 7'd0;
    end else begin
      done_q <= 1'b0;
      if (!busy_q) begin
        if (start_i) begin
          busy_q    <= 1'b1;
          div_cnt_q <= divider_i;
          bit_cnt_q <= len_eff;
          sck_q     <= 1'b0;
        end
      end else if (half_tick) begin
        div_cnt_q <= divider_i;
        sck_q     <= !sck_q;
        // Falling edge closes one bit
        if (sck_q) begin
          bit_cnt_q <= bit_cnt_q - 7'd1;
          if (bit_cnt_q == 7'd1) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end
        end
      end else begin
        div_cnt_q <= div_cnt_q - 16'd1;
      end
    end
  end

  // Shared shift register, TX leaves at the top and RX enters at the bottom
  always_ff @(posedge clock) begin
    if (!busy_q && start_i) begin
      // MSB of the frame lands on bit 63
      shift_q <= tx_i << (7'(MAX_LEN) - len_eff);
    end else if (half_tick) begin
      if (!sck_q) begin
        // Rising edge, sample
        miso_q <= miso_i;
      end else begin
        // Falling edge, next bit out
        shift_q <= {shift_q[62:0], miso_q};
      end
    end
  end

  assign busy_o = busy_q;
  assign done_o = done_q;
  // Upper bits are zero once a short frame completes
  assign rx_o   = shift_q;
  assign sck_o  = sck_q;
  assign mosi_o = busy_q & shift_q[63];

endmodule

/* hw/xip_read_sequencer.sv */
`timescale 1ns/1ps
`include "spi_flash_defs.svh"

module xip_read_sequencer
  import spi_flash_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        start_i,
  input  logic [23:0] flash_addr_i,
  input  reg_rsp_t    rsp_i,
  output reg_req_t    req_o,
  output logic        ready_o,
  output logic [31:0] rdata_o
);

  xip_state_e  state_q;
  logic [23:0] addr_q;
  logic [31:0] rdata_q;
  logic        bsy_seen;

  // GO_BSY in the polled CTRL word
  assign bsy_seen = rsp_i.rdata[`CTRL_GO_BSY_BIT];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q <= LOAD_CMD;
          end
        end
        LOAD_CMD: begin
          if (rsp_i.ack) begin
            state_q <= SET_DIVIDER;
          end
        end
        SET_DIVIDER: begin
          if (rsp_i.ack) begin
            state_q <= SELECT;
          end
        end
        SELECT: begin
          if (rsp_i.ack) begin
            state_q <= START;
          end
        end
        START: begin
          if (rsp_i.ack) begin
            state_q <= POLL;
          end
        end
        POLL: begin
          // Keep reading CTRL while the frame runs
          if (rsp_i.ack && !bsy_seen) begin
            state_q <= DESELECT;
          end
        end
        DESELECT: begin
          if (rsp_i.ack) begin
            state_q <= READ_RX;
          end
        end
        READ_RX: begin
          if (rsp_i.ack) begin
            state_q <= DONE;
          end
        end
        DONE: begin
          // Wait for the APB access to end
          if (!start_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == IDLE && start_i) begin
      addr_q <= flash_addr_i;
    end
    if (state_q == READ_RX && rsp_i.ack) begin
      rdata_q <= rsp_i.rdata;
    end
  end

  // One register access per step, stb held until ack
  always_comb begin
    req_o       = '0;
    req_o.strb  = 4'hF;
    req_o.we    = 1'b1;
    req_o.stb   = 1'b1;
    case (state_q)
      LOAD_CMD: begin
        // Command and address go out first
        req_o.adr   = REG_TX1;
        req_o.wdata = {`FLASH_READ_CMD, addr_q};
      end
      SET_DIVIDER: begin
        req_o.adr   = REG_DIVIDER;
        req_o.wdata = {16'd0, `XIP_DIVIDER};
      end
      SELECT: begin
        req_o.adr   = REG_SS;
        req_o.wdata = 32'd1;
      end
      START: begin
        req_o.adr = REG_CTRL;
        req_o.wdata[`CTRL_CHAR_LEN_W-1:0] = `XIP_CHAR_LEN;
        req_o.wdata[`CTRL_GO_BSY_BIT]     = 1'b1;
      end
      POLL: begin
        req_o.adr  = REG_CTRL;
        req_o.we   = 1'b0;
        req_o.strb = 4'h0;
      end
      DESELECT: begin
        req_o.adr = REG_SS;
      end
      READ_RX: begin
        // Last 32 bits of the frame
        req_o.adr  = REG_RX0;
        req_o.we   = 1'b0;
        req_o.strb = 4'h0;
      end
      default: begin
        req_o.stb  = 1'b0;
        req_o.we   = 1'b0;
        req_o.strb = 4'h0;
      end
    endcase
  end

  // Only while the access is still open
  assign ready_o = (state_q == DONE) && start_i;
  assign rdata_o = rdata_q;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_spi_flash -o tb_spi_flash
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_spi_flash
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation finished"
exit 0

/* sim/spi_flash_asserts.sv */
`timescale 1ns/1ps
`include "spi_flash_defs.svh"

module spi_flash_asserts (
  input logic                   clock,
  input logic                   reset,
  input logic                   psel_i,
  input logic                   penable_i,
  input logic                   pready_i,
  input logic [`SPI_SS_NUM-1:0] ss_i,
  input logic                   sck_i
);

  // Count of failed assertions
  int unsigned fail_count = 0;

  // Completion only inside an access phase
  pready_in_access: assert property (@(posedge clock) disable iff (reset)
    pready_i |-> (psel_i && penable_i))
    else begin
      fail_count = fail_count + 1;
      $error("pready high outside an APB access phase");
    end

  // Select lines are active low, one slave at a time
  one_slave_selected: assert property (@(posedge clock) disable iff (reset)
    $countones(~ss_i) <= 1)
    else begin
      fail_count = fail_count + 1;
      $error("more than one slave select is active");
    end

  // No clock on the bus without a selected slave
  sck_idle_when_deselected: assert property (@(posedge clock) disable iff (reset)
    (&ss_i) |-> !sck_i)
    else begin
      fail_count = fail_count + 1;
      $error("sck toggles while no slave is selected");
    end

endmodule

/* sim/spi_flash_model.sv */
`timescale 1ns/1ps
`include "spi_flash_defs.svh"

module spi_flash_model (
  input  logic sck_i,
  input  logic cs_n_i,
  input  logic mosi_i,
  output logic miso_o
);

  // Opcode in 31:24, start address in 23:0
  logic [31:0] cmd_q = 32'd0;
  int unsigned bit_cnt = 0;
  logic        miso_q = 1'b1;

  function automatic logic [7:0] data_byte(input logic [23:0] addr);
    return addr[7:0] ^ 8'h5A;
  endfunction

  function automatic logic next_bit(input logic [31:0] cmd, input int unsigned n);
    logic [7:0] data;
    // High through the command phase and for unknown opcodes
    if (n < 32 || cmd[31:24] != `FLASH_READ_CMD) begin
      return 1'b1;
    end
    // Pointer counts every frame byte, so data starts at addr + 4
    data = data_byte(cmd[23:0] + 24'(n / 8));
    return data[7 - (n % 8)];
  endfunction

  // Mode 0 sample on the rising edge, frame restarts on deselect
  always @(posedge sck_i or posedge cs_n_i) begin
    if (cs_n_i) begin
      bit_cnt <= 0;
    end else begin
      if (bit_cnt < 32) begin
        cmd_q <= {cmd_q[30:0], mosi_i};
      end
      bit_cnt <= bit_cnt + 1;
    end
  end

  // Next bit goes out on the falling edge
  always @(negedge sck_i or posedge cs_n_i) begin
    if (cs_n_i) begin
      miso_q <= 1'b1;
    end else begin
      miso_q <= next_bit(cmd_q, bit_cnt);
    end
  end

  assign miso_o = miso_q;

endmodule

/* sim/tb_spi_flash.sv */
`timescale 1ns/1ps
`include "spi_flash_defs.svh"

module tb_spi_flash;

  localparam int N_REG  = 40;
  localparam int N_XFER = 16;
  localparam int N_XIP  = 16;
  localparam int N_ERR  = 16;
  localparam int N_IRQ  = 3;
  localparam int N_OPS  = N_REG + N_XFER + N_XIP + N_ERR + N_IRQ;

  logic                   clock;
  logic                   reset;
  logic [31:0]            paddr;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [31:0]            pwdata;
  logic [3:0]             pstrb;
  logic                   pready;
  logic [31:0]            prdata;
  logic                   pslverr;
  logic                   spi_sck;
  logic [`SPI_SS_NUM-1:0] spi_ss;
  logic                   spi_mosi;
  logic                   spi_miso;
  logic                   spi_irq;

  integer      seed;
  // Expected DIVIDER and SS contents
  logic [31:0] div_model;
  logic [31:0] ss_model;

  spi_flash_apb_top dut (
    .clock      (clock),
    .reset      (reset),
    .paddr_i    (paddr),
    .psel_i     (psel),
    .penable_i  (penable),
    .pwrite_i   (pwrite),
    .pwdata_i   (pwdata),
    .pstrb_i    (pstrb),
    .pready_o   (pready),
    .prdata_o   (prdata),
    .pslverr_o  (pslverr),
    .spi_sck_o  (spi_sck),
    .spi_ss_o   (spi_ss),
    .spi_mosi_o (spi_mosi),
    .spi_miso_i (spi_miso),
    .spi_irq_o  (spi_irq)
  );

  // Flash sits on slave select 0
  spi_flash_model u_flash (
    .sck_i  (spi_sck),
    .cs_n_i (spi_ss[0]),
    .mosi_i (spi_mosi),
    .miso_o (spi_miso)
  );

  bind spi_flash_apb_top spi_flash_asserts u_asserts (
    .clock     (clock),
    .reset     (reset),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pready_i  (pready_o),
    .ss_i      (spi_ss_o),
    .sck_i     (spi_sck_o)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // 400 cycles per operation
  initial begin
    repeat (N_OPS * 400) @(posedge clock);
    $display("** FAIL **");
    $fatal(1, "Timeout after %0d cycles, an access never completed", N_OPS * 400);
  end

  function automatic logic [31:0] strobe_merge(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [3:0]  strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  function automatic logic [7:0] flash_byte(input logic [23:0] addr);
    return addr[7:0] ^ 8'h5A;
  endfunction

  // RX0 after an XIP read, first byte on top
  function automatic logic [31:0] xip_word(input logic [23:0] a);
    return {flash_byte(a + 24'd4), flash_byte(a + 24'd5),
            flash_byte(a + 24'd6), flash_byte(a + 24'd7)};
  endfunction

  // Received word for TX[len-1:0] sent MSB first
  function automatic logic [63:0] frame_reply(input logic [63:0] tx, input int len);
    logic [63:0] frame;
    logic [63:0] rx;
    logic [7:0]  data;
    logic        miso;
    frame = tx << (64 - len);
    rx    = 64'd0;
    for (int n = 0; n < len; n++) begin
      miso = 1'b1;
      if (n >= 32 && frame[63:56] == `FLASH_READ_CMD) begin
        data = flash_byte(frame[55:32] + 24'(n / 8));
        miso = data[7 - (n % 8)];
      end
      rx = {rx[62:0], miso};
    end
    return rx;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("** FAIL **");
      $fatal(1, "Stopping at the first error");
    end
  endtask

  task automatic apb_transfer(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] strb,
                              output logic [31:0] rdata, output logic err);
    @(posedge clock);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    pstrb   = strb;
    @(posedge clock);
    #1;
    penable = 1'b1;
    // Outputs are settled at the falling edge
    @(negedge clock);
    while (!pready) begin
      @(negedge clock);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clock);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_reg(input logic [4:0] ofs, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(1'b1, `SPI_REGS_START + {27'd0, ofs}, data, strb, rdata, err);
    check_value("pslverr", 64'(err), 64'd0);
  endtask

  task automatic read_reg(input logic [4:0] ofs, output logic [31:0] data);
    logic err;
    apb_transfer(1'b0, `SPI_REGS_START + {27'd0, ofs}, 32'd0, 4'h0, data, err);
    check_value("pslverr", 64'(err), 64'd0);
  endtask

  task automatic poll_until_idle(output logic [31:0] ctrl);
    read_reg(`SPI_REG_CTRL_OFS, ctrl);
    while (ctrl[`CTRL_GO_BSY_BIT]) begin
      read_reg(`SPI_REG_CTRL_OFS, ctrl);
    end
  endtask

  task automatic expect_ss_pins();
    logic [`SPI_SS_NUM-1:0] pins;
    pins = ~ss_model[`SPI_SS_NUM-1:0];
    check_value("spi_ss_o", 64'(spi_ss), 64'(pins));
  endtask

  task automatic expect_regs_unchanged();
    logic [31:0] rdata;
    read_reg(`SPI_REG_DIVIDER_OFS, rdata);
    check_value("DIVIDER", 64'(rdata), 64'(div_model));
    read_reg(`SPI_REG_SS_OFS, rdata);
    check_value("SS", 64'(rdata), 64'(ss_model));
    expect_ss_pins();
  endtask

  task automatic register_readback();
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [3:0]  strb;
    int          sel;
    for (int i = 0; i < N_REG; i++) begin
      wdata = $random(seed);
      strb  = 4'($random(seed));
      if (i % 2 == 0) begin
        write_reg(`SPI_REG_DIVIDER_OFS, wdata, strb);
        div_model = strobe_merge(div_model, wdata, strb) & 32'h0000_FFFF;
        read_reg(`SPI_REG_DIVIDER_OFS, rdata);
        check_value("DIVIDER", 64'(rdata), 64'(div_model));
      end else begin
        // One-hot or empty, so only one slave is ever selected
        sel = int'($unsigned($random(seed)) % 9);
        wdata[7:0] = (sel == 8) ? 8'h00 : 8'(1 << sel);
        write_reg(`SPI_REG_SS_OFS, wdata, strb);
        ss_model = strobe_merge(ss_model, wdata, strb) & 32'h0000_00FF;
        read_reg(`SPI_REG_SS_OFS, rdata);
        check_value("SS", 64'(rdata), 64'(ss_model));
        expect_ss_pins();
      end
    end
  endtask

  task automatic direct_transfers();
    logic [63:0] tx;
    logic [63:0] exp;
    logic [31:0] ctrl;
    logic [31:0] rx0;
    logic [31:0] rx1;
    logic [15:0] div16;
    int          len;
    for (int i = 0; i < N_XFER; i++) begin
      len   = 8 * (1 + int'($unsigned($random(seed)) % 8));
      div16 = 16'($unsigned($random(seed)) % 2);
      tx    = {$random(seed), $random(seed)};
      // Half of the long frames carry a read command
      if (len >= 32 && 1'($random(seed))) begin
        tx[len-1 -: 8] = `FLASH_READ_CMD;
      end
      write_reg(`SPI_REG_DIVIDER_OFS, {16'd0, div16}, 4'hF);
      div_model = {16'd0, div16};
      write_reg(`SPI_REG_SS_OFS, 32'd1, 4'hF);
      ss_model = 32'd1;
      write_reg(`SPI_REG_RX0_OFS, tx[31:0], 4'hF);
      write_reg(`SPI_REG_RX1_OFS, tx[63:32], 4'hF);
      ctrl = 32'(len);
      ctrl[`CTRL_GO_BSY_BIT] = 1'b1;
      write_reg(`SPI_REG_CTRL_OFS, ctrl, 4'hF);
      poll_until_idle(ctrl);
      check_value("CTRL.CHAR_LEN", 64'(ctrl[6:0]), 64'(len));
      write_reg(`SPI_REG_SS_OFS, 32'd0, 4'hF);
      ss_model = 32'd0;
      read_reg(`SPI_REG_RX0_OFS, rx0);
      read_reg(`SPI_REG_RX1_OFS, rx1);
      exp = frame_reply(tx, len);
      check_value("RX", {rx1, rx0}, exp);
      check_value("spi_irq_o", 64'(spi_irq), 64'd0);
    end
  endtask

  task automatic xip_reads();
    logic [31:0] addr;
    logic [31:0] rdata;
    logic        err;
    for (int i = 0; i < N_XIP; i++) begin
      addr = `SPI_FLASH_START | (32'($random(seed)) & 32'h0FFF_FFFF);
      apb_transfer(1'b0, addr, 32'd0, 4'h0, rdata, err);
      check_value("pslverr", 64'(err), 64'd0);
      check_value("prdata", 64'(rdata), 64'(xip_word(addr[23:0])));
      // Sequencer leaves divider at its XIP value and all slaves off
      div_model = 32'(`XIP_DIVIDER);
      ss_model  = 32'd0;
      expect_ss_pins();
    end
    expect_regs_unchanged();
  endtask

  task automatic error_accesses();
    logic [31:0] addr;
    logic [31:0] rdata;
    logic        wr;
    logic        err;
    for (int i = 0; i < N_ERR; i++) begin
      if (i % 2 == 0) begin
        addr = $random(seed);
        if ((addr >= `SPI_FLASH_START && addr <= `SPI_FLASH_END) ||
            (addr >= `SPI_REGS_START && addr <= `SPI_REGS_END)) begin
          addr = addr ^ 32'h8000_0000;
        end
        // Low bits aimed at DIVIDER or SS
        addr[4:0] = 1'($random(seed)) ? `SPI_REG_DIVIDER_OFS : `SPI_REG_SS_OFS;
        wr = 1'($random(seed));
      end else begin
        addr = `SPI_FLASH_START | (32'($random(seed)) & 32'h0FFF_FFFF);
        wr   = 1'b1;
      end
      apb_transfer(wr, addr, $random(seed), 4'hF, rdata, err);
      check_value("pslverr", 64'(err), 64'd1);
      expect_regs_unchanged();
    end
  endtask

  task automatic irq_sequence();
    logic [31:0] ctrl;
    for (int i = 0; i < N_IRQ; i++) begin
      write_reg(`SPI_REG_SS_OFS, 32'd1, 4'hF);
      ss_model = 32'd1;
      write_reg(`SPI_REG_RX0_OFS, $random(seed), 4'hF);
      ctrl = 32'd8;
      ctrl[`CTRL_GO_BSY_BIT] = 1'b1;
      ctrl[`CTRL_IE_BIT]     = 1'b1;
      write_reg(`SPI_REG_CTRL_OFS, ctrl, 4'hF);
      check_value("spi_irq_o", 64'(spi_irq), 64'd0);
      poll_until_idle(ctrl);
      check_value("spi_irq_o", 64'(spi_irq), 64'd1);
      write_reg(`SPI_REG_SS_OFS, 32'd0, 4'hF);
      ss_model = 32'd0;
      // CTRL write without GO_BSY clears the interrupt
      ctrl = 32'd8;
      ctrl[`CTRL_IE_BIT] = 1'b1;
      write_reg(`SPI_REG_CTRL_OFS, ctrl, 4'hF);
      check_value("spi_irq_o", 64'(spi_irq), 64'd0);
    end
  endtask

  initial begin
    seed      = 78;
    div_model = 32'(`XIP_DIVIDER);
    ss_model  = 32'd0;
    reset     = 1'b1;
    paddr     = 32'd0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = 32'd0;
    pstrb     = 4'h0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;

    // Idle outputs after reset
    check_value("pready_o", 64'(pready), 64'd0);
    check_value("pslverr_o", 64'(pslverr), 64'd0);
    check_value("spi_sck_o", 64'(spi_sck), 64'd0);
    check_value("spi_irq_o", 64'(spi_irq), 64'd0);
    expect_regs_unchanged();

    register_readback();
    direct_transfers();
    xip_reads();
    error_accesses();
    irq_sequence();

    if (dut.u_asserts.fail_count == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("** FAIL **");
      $fatal(1, "%0d protocol assertion failures", dut.u_asserts.fail_count);
    end
  end

endmodule

/* sources.f */
+incdir+hw
hw/spi_flash_pkg.sv
hw/spi_shift_engine.sv
hw/spi_master_regs.sv
hw/xip_read_sequencer.sv
hw/spi_flash_apb_top.sv
sim/spi_flash_model.sv
sim/spi_flash_asserts.sv
sim/tb_spi_flash.sv
